//--- hdl/leaf_interface.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_interface #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ADDR      = '0,
    parameter int                             FIFO_ADDR_BITS = 7
) (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  leaf_pkg::packet_t                                             din_leaf_bft2interface,
    input  logic                                                          resend,
    input  logic                                                          ap_start,
    input  logic                                                          ack_user2interface,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] din_leaf_user2interface,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             vld_user2interface,
    output leaf_pkg::packet_t                                             dout_leaf_interface2bft,
    output logic                                                          user_rst_n,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]                              dout_leaf_interface2user,
    output logic                                                          vld_interface2user,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             ack_interface2user
);

    leaf_pkg::cfg_wr_t cfg_wr;

    // kernel stays in reset until the first ap_start after a leaf reset.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            user_rst_n <= 1'b0;
        end else if (ap_start) begin
            user_rst_n <= 1'b1;
        end
    end

    leaf_rx_depacketizer #(
        .LEAF_ADDR      (LEAF_ADDR),
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) rx_inst (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .ack_user2interface       (ack_user2interface),
        .cfg_wr                   (cfg_wr),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user)
    );

    leaf_tx_packetizer tx_inst (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .cfg_wr                  (cfg_wr),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .resend                  (resend),
        .ack_interface2user      (ack_interface2user),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

//--- hdl/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    // field widths of a network packet.
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int SEQ_BITS     = 7;
    localparam int PAYLOAD_BITS = 32;

    localparam int NUM_OUT_PORTS = 5;

    // index of a kernel output port, 1 to 5 on the wire.
    localparam int CFG_IDX_BITS = 3;

    // configuration payload layout.
    localparam int CFG_IDX_LSB  = 0;
    localparam int CFG_LEAF_LSB = 4;
    localparam int CFG_PORT_LSB = 9;

    // reserved input ports.
    localparam logic [PORT_BITS-1:0] CFG_PORT  = 4'd0;
    localparam logic [PORT_BITS-1:0] DATA_PORT = 4'd1;

    typedef struct packed {
        logic                    valid;
        logic [LEAF_BITS-1:0]    dst_leaf;
        logic [PORT_BITS-1:0]    dst_port;
        logic [SEQ_BITS-1:0]     seq;
        logic [PAYLOAD_BITS-1:0] payload;
    } packet_t;

    typedef struct packed {
        logic                    en;
        logic [CFG_IDX_BITS-1:0] out_port;
        logic [LEAF_BITS-1:0]    dst_leaf;
        logic [PORT_BITS-1:0]    dst_port;
    } cfg_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        WAIT_ACK
    } kernel_state_t;

endpackage

`default_nettype wire

//--- hdl/leaf_rx_depacketizer.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_rx_depacketizer #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ADDR      = '0,
    parameter int                             FIFO_ADDR_BITS = 7
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  leaf_pkg::packet_t                 din_leaf_bft2interface,
    input  logic                              ack_user2interface,
    output leaf_pkg::cfg_wr_t                 cfg_wr,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] dout_leaf_interface2user,
    output logic                              vld_interface2user
);

    localparam int DEPTH = 1 << FIFO_ADDR_BITS;

    logic                              pkt_hit;
    logic [leaf_pkg::PORT_BITS-1:0]    pkt_port;
    logic [leaf_pkg::PAYLOAD_BITS-1:0] pkt_payload;
    logic [leaf_pkg::CFG_IDX_BITS-1:0] cfg_idx;

    logic [leaf_pkg::PAYLOAD_BITS-1:0] fifo_mem [DEPTH];
    logic [FIFO_ADDR_BITS:0]           wr_ptr;
    logic [FIFO_ADDR_BITS:0]           rd_ptr;
    logic                              fifo_empty;
    logic                              fifo_full;
    logic                              fifo_wr;
    logic                              fifo_rd;

    // input stage, only packets for this leaf are kept.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_hit <= 1'b0;
        end else begin
            pkt_hit <= din_leaf_bft2interface.valid &&
                       (din_leaf_bft2interface.dst_leaf == LEAF_ADDR);
        end
    end

    always_ff @(posedge clk) begin
        pkt_port    <= din_leaf_bft2interface.dst_port;
        pkt_payload <= din_leaf_bft2interface.payload;
    end

    // configuration decode.
    assign cfg_idx = pkt_payload[leaf_pkg::CFG_IDX_LSB +: leaf_pkg::CFG_IDX_BITS];

    always_comb begin
        cfg_wr.en       = pkt_hit && (pkt_port == leaf_pkg::CFG_PORT) &&
                          (cfg_idx != '0) &&
                          (cfg_idx <= leaf_pkg::CFG_IDX_BITS'(leaf_pkg::NUM_OUT_PORTS));
        cfg_wr.out_port = cfg_idx;
        cfg_wr.dst_leaf = pkt_payload[leaf_pkg::CFG_LEAF_LSB +: leaf_pkg::LEAF_BITS];
        cfg_wr.dst_port = pkt_payload[leaf_pkg::CFG_PORT_LSB +: leaf_pkg::PORT_BITS];
    end

    // circular FIFO, the extra pointer bit tells full from empty.
    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                        (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);

    // a full FIFO drops the packet.
    assign fifo_wr = pkt_hit && (pkt_port == leaf_pkg::DATA_PORT) && !fifo_full;
    assign fifo_rd = !fifo_empty && (!vld_interface2user || ack_user2interface);

    always_ff @(posedge clk) begin
        if (fifo_wr) begin
            fifo_mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= pkt_payload;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (fifo_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fifo_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // output register toward the kernel.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_interface2user <= 1'b0;
        end else if (fifo_rd) begin
            vld_interface2user <= 1'b1;
        end else if (ack_user2interface) begin
            vld_interface2user <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_rd) begin
            dout_leaf_interface2user <= fifo_mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

//--- hdl/leaf_top.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_top #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ADDR      = '0,
    parameter int                             FIFO_ADDR_BITS = 7
) (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    input  logic              resend,
    input  logic              ap_start,
    output leaf_pkg::packet_t dout_leaf_interface2bft
);

    logic user_rst_n;

    // input port 1 toward the kernel.
    logic [leaf_pkg::PAYLOAD_BITS-1:0] dout_leaf_interface2user;
    logic                              vld_interface2user;
    logic                              ack_user2interface;

    // output ports 1 to 5 from the kernel, index 0 is port 1.
    logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] din_leaf_user2interface;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             vld_user2interface;
    logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             ack_interface2user;

    leaf_interface #(
        .LEAF_ADDR      (LEAF_ADDR),
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) leaf_interface_inst (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .din_leaf_bft2interface   (din_leaf_bft2interface),
        .resend                   (resend),
        .ap_start                 (ap_start),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .dout_leaf_interface2bft  (dout_leaf_interface2bft),
        .user_rst_n               (user_rst_n),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_interface2user       (ack_interface2user)
    );

    user_kernel user_kernel_inst (
        .clk                      (clk),
        .user_rst_n               (user_rst_n),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_interface2user       (ack_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface)
    );

endmodule

`default_nettype wire

//--- hdl/leaf_tx_packetizer.sv
`timescale 1ns/10ps
`default_nettype none

module leaf_tx_packetizer (
    input  logic                                                          clk,
    input  logic                                                          rst_n,
    input  leaf_pkg::cfg_wr_t                                             cfg_wr,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] din_leaf_user2interface,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             vld_user2interface,
    input  logic                                                          resend,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             ack_interface2user,
    output leaf_pkg::packet_t                                             dout_leaf_interface2bft
);

    localparam int N  = leaf_pkg::NUM_OUT_PORTS;
    localparam int IW = leaf_pkg::CFG_IDX_BITS;

    logic [leaf_pkg::LEAF_BITS-1:0]    dst_leaf_tbl [N];
    logic [leaf_pkg::PORT_BITS-1:0]    dst_port_tbl [N];
    logic [leaf_pkg::SEQ_BITS-1:0]     seq_cnt [N];
    logic [leaf_pkg::PAYLOAD_BITS-1:0] hold_data [N];
    logic [N-1:0]                      hold_full;

    logic [IW-1:0] cfg_idx;
    logic [IW-1:0] rr_ptr;
    logic [IW:0]   rr_sum;
    logic [IW-1:0] rr_cand;
    logic          grant_vld;
    logic [IW-1:0] grant_idx;

    leaf_pkg::packet_t out_q;

    // out_port 1 to 5 maps to table entry 0 to 4.
    assign cfg_idx = cfg_wr.out_port - 1'b1;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                dst_leaf_tbl[i] <= '0;
                dst_port_tbl[i] <= '0;
            end
        end else if (cfg_wr.en) begin
            dst_leaf_tbl[cfg_idx] <= cfg_wr.dst_leaf;
            dst_port_tbl[cfg_idx] <= cfg_wr.dst_port;
        end
    end

    // a port accepts a word only while its holding register is empty.
    assign ack_interface2user = ~hold_full;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_full <= '0;
        end else begin
            for (int i = 0; i < N; i++) begin
                if (vld_user2interface[i] && ack_interface2user[i]) begin
                    hold_full[i] <= 1'b1;
                end else if (grant_vld && (grant_idx == IW'(i))) begin
                    hold_full[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (vld_user2interface[i] && ack_interface2user[i]) begin
                hold_data[i] <= din_leaf_user2interface[i];
            end
        end
    end

    // first full register at or after the pointer wins.
    always_comb begin
        grant_vld = 1'b0;
        grant_idx = '0;
        rr_sum    = '0;
        rr_cand   = '0;
        if (!resend) begin
            for (int k = 0; k < N; k++) begin
                rr_sum  = {1'b0, rr_ptr} + (IW+1)'(k);
                rr_cand = (rr_sum >= (IW+1)'(N)) ? IW'(rr_sum - (IW+1)'(N)) : rr_sum[IW-1:0];
                if (!grant_vld && hold_full[rr_cand]) begin
                    grant_vld = 1'b1;
                    grant_idx = rr_cand;
                end
            end
        end
    end

    // the packet register holds its word through resend.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_q  <= '0;
            rr_ptr <= '0;
            for (int i = 0; i < N; i++) begin
                seq_cnt[i] <= '0;
            end
        end else if (!resend) begin
            if (grant_vld) begin
                out_q.valid    <= 1'b1;
                out_q.dst_leaf <= dst_leaf_tbl[grant_idx];
                out_q.dst_port <= dst_port_tbl[grant_idx];
                out_q.seq      <= seq_cnt[grant_idx];
                out_q.payload  <= hold_data[grant_idx];
                seq_cnt[grant_idx] <= seq_cnt[grant_idx] + 1'b1;
                rr_ptr <= (grant_idx == IW'(N-1)) ? '0 : grant_idx + 1'b1;
            end else begin
                out_q <= '0;
            end
        end
    end

    assign dout_leaf_interface2bft = resend ? '0 : out_q;

endmodule

`default_nettype wire

//--- hdl/user_kernel.sv
`timescale 1ns/10ps
`default_nettype none

module user_kernel (
    input  logic                                                          clk,
    input  logic                                                          user_rst_n,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0]                              dout_leaf_interface2user,
    input  logic                                                          vld_interface2user,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             ack_interface2user,
    output logic                                                          ack_user2interface,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] din_leaf_user2interface,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]                             vld_user2interface
);

    localparam int IW = leaf_pkg::CFG_IDX_BITS;

    leaf_pkg::kernel_state_t           state;
    logic [IW-1:0]                     target;
    logic [leaf_pkg::PAYLOAD_BITS-1:0] word_q;
    logic                              take;

    // ack is a register so the kernel never acks while held in reset.
    assign take = (state == leaf_pkg::IDLE) && ack_user2interface && vld_interface2user;

    always_ff @(posedge clk) begin
        if (!user_rst_n) begin
            state              <= leaf_pkg::IDLE;
            target             <= '0;
            ack_user2interface <= 1'b0;
        end else begin
            case (state)
                leaf_pkg::IDLE: begin
                    if (take) begin
                        ack_user2interface <= 1'b0;
                        state              <= leaf_pkg::FORWARD;
                    end else begin
                        ack_user2interface <= 1'b1;
                    end
                end
                leaf_pkg::FORWARD: begin
                    state <= leaf_pkg::WAIT_ACK;
                end
                leaf_pkg::WAIT_ACK: begin
                    if (ack_interface2user[target]) begin
                        target <= (target == IW'(leaf_pkg::NUM_OUT_PORTS-1)) ? '0 : target + 1'b1;
                        ack_user2interface <= 1'b1;
                        state              <= leaf_pkg::IDLE;
                    end
                end
                default: begin
                    state <= leaf_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word_q <= dout_leaf_interface2user;
        end
    end

    // word on the target lane, vld raised once the data is settled.
    always_comb begin
        din_leaf_user2interface = '0;
        vld_user2interface      = '0;
        if (state != leaf_pkg::IDLE) begin
            din_leaf_user2interface[target] = word_q;
        end
        if (state == leaf_pkg::WAIT_ACK) begin
            vld_user2interface[target] = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the leaf testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_leaf_top \
    -f vlog.f \
    -o tb_leaf_top

./obj_dir/tb_leaf_top

//--- testbench/tb_leaf_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_leaf_top;

    localparam logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ADDR = 5'd9;
    localparam int FIFO_ADDR_BITS = 7;
    localparam int NUM_PORTS      = leaf_pkg::NUM_OUT_PORTS;
    localparam int MAX_IN_FLIGHT  = 40;
    localparam int PHASE_WORDS    = 180;
    localparam int TIMEOUT_CYCLES = 5000;

    logic              clk;
    logic              rst_n;
    logic              resend;
    logic              ap_start;
    leaf_pkg::packet_t din_leaf_bft2interface;
    leaf_pkg::packet_t dout_leaf_interface2bft;

    // reference model state.
    leaf_pkg::packet_t              exp_q [NUM_PORTS][$];
    logic [leaf_pkg::LEAF_BITS-1:0] tbl_leaf [NUM_PORTS];
    logic [leaf_pkg::PORT_BITS-1:0] tbl_port [NUM_PORTS];
    logic [leaf_pkg::SEQ_BITS-1:0]  model_seq [NUM_PORTS];
    int                             model_target;

    int          out_count;
    int          resend_left;
    bit          started;
    logic [31:0] rng_state;

    leaf_top #(
        .LEAF_ADDR      (LEAF_ADDR),
        .FIFO_ADDR_BITS (FIFO_ADDR_BITS)
    ) uut (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .resend                  (resend),
        .ap_start                (ap_start),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(rand32() % 32'(n));
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    function automatic leaf_pkg::packet_t make_packet(input logic v,
                                                       input logic [4:0] leaf,
                                                       input logic [3:0] port,
                                                       input logic [31:0] payload);
        leaf_pkg::packet_t pkt;
        pkt.valid    = v;
        pkt.dst_leaf = leaf;
        pkt.dst_port = port;
        pkt.seq      = 7'(rand32());
        pkt.payload  = payload;
        return pkt;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_packet(input string name, input leaf_pkg::packet_t exp,
                                input leaf_pkg::packet_t act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("CHECK FAILED %s: expected %b, actual %b", name, exp, act));
        end
    endtask

    // one stimulus cycle with random resend windows of 1 to 6 cycles.
    task automatic next_cycle(input leaf_pkg::packet_t pkt);
        @(negedge clk);
        din_leaf_bft2interface = pkt;
        if (resend_left > 0) begin
            resend      = 1'b1;
            resend_left = resend_left - 1;
        end else if (rand_below(10) == 0) begin
            resend      = 1'b1;
            resend_left = rand_below(6);
        end else begin
            resend = 1'b0;
        end
    endtask

    task automatic send_packet(input leaf_pkg::packet_t pkt);
        int gap;
        next_cycle(pkt);
        gap = rand_below(4);
        repeat (gap) next_cycle('0);
    endtask

    task automatic wait_room();
        int cycles;
        cycles = 0;
        while (outstanding() >= MAX_IN_FLIGHT) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run("timeout: output packets stopped flowing, no room for a new data packet");
            end
            next_cycle('0);
            cycles++;
        end
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while (outstanding() > 0) begin
            if (cycles >= TIMEOUT_CYCLES) begin
                fail_run($sformatf("timeout: %0d words never left the leaf (%s)",
                                   outstanding(), what));
            end
            next_cycle('0);
            cycles++;
        end
    endtask

    // the kernel sends words to ports 1 to 5 in turn and each port stamps its own seq.
    task automatic send_data();
        leaf_pkg::packet_t pkt;
        leaf_pkg::packet_t exp;
        wait_room();
        pkt          = make_packet(1'b1, LEAF_ADDR, leaf_pkg::DATA_PORT, rand32());
        exp.valid    = 1'b1;
        exp.dst_leaf = tbl_leaf[model_target];
        exp.dst_port = tbl_port[model_target];
        exp.seq      = model_seq[model_target];
        exp.payload  = pkt.payload;
        exp_q[model_target].push_back(exp);
        model_seq[model_target] = model_seq[model_target] + 7'd1;
        model_target = (model_target + 1) % NUM_PORTS;
        send_packet(pkt);
    endtask

    // destinations stay unique so an output can be traced to its port.
    task automatic pick_dest(input int idx);
        logic [8:0] cand;
        bit         clash;
        cand = 9'(rand32());
        for (int tries = 0; tries < 8; tries++) begin
            clash = 1'b0;
            for (int j = 0; j < NUM_PORTS; j++) begin
                if (j != idx && {tbl_leaf[j], tbl_port[j]} == cand) begin
                    clash = 1'b1;
                end
            end
            if (clash) begin
                cand = cand + 9'd1;
            end
        end
        tbl_leaf[idx] = cand[8:4];
        tbl_port[idx] = cand[3:0];
    endtask

    task automatic reconfigure(input bit all_ports);
        logic [31:0] pl;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (all_ports || rand_below(2) == 0) begin
                pick_dest(i);
                pl = rand32();
                pl[leaf_pkg::CFG_IDX_LSB +: leaf_pkg::CFG_IDX_BITS] = 3'(i + 1);
                pl[leaf_pkg::CFG_LEAF_LSB +: leaf_pkg::LEAF_BITS]   = tbl_leaf[i];
                pl[leaf_pkg::CFG_PORT_LSB +: leaf_pkg::PORT_BITS]   = tbl_port[i];
                send_packet(make_packet(1'b1, LEAF_ADDR, leaf_pkg::CFG_PORT, pl));
            end
        end
    endtask

    // packets the leaf must ignore.
    task automatic send_junk();
        int                             kind;
        int                             sel;
        logic [31:0]                    pl;
        logic [leaf_pkg::LEAF_BITS-1:0] leaf;
        kind = rand_below(4);
        pl   = rand32();
        case (kind)
            0: begin
                leaf = 5'(rand_below(32));
                if (leaf == LEAF_ADDR) begin
                    leaf = leaf + 5'd1;
                end
                send_packet(make_packet(1'b1, leaf, 4'(rand_below(2)), pl));
            end
            1: send_packet(make_packet(1'b1, LEAF_ADDR, 4'(2 + rand_below(14)), pl));
            2: send_packet(make_packet(1'b0, LEAF_ADDR, 4'(rand_below(2)), pl));
            default: begin
                sel = rand_below(3);
                pl[leaf_pkg::CFG_IDX_LSB +: leaf_pkg::CFG_IDX_BITS] = (sel == 0) ? 3'd0 : 3'(5 + sel);
                send_packet(make_packet(1'b1, LEAF_ADDR, leaf_pkg::CFG_PORT, pl));
            end
        endcase
    endtask

    task automatic match_output(input leaf_pkg::packet_t pkt);
        int port;
        port = -1;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (port < 0 && exp_q[i].size() > 0 &&
                exp_q[i][0].dst_leaf == pkt.dst_leaf && exp_q[i][0].dst_port == pkt.dst_port) begin
                port = i;
            end
        end
        if (port < 0) begin
            fail_run($sformatf("unexpected output packet %h, no pending word has its destination",
                               pkt));
        end
        if (out_count == 0) begin
            check_level("first output comes from port 1", 1'b1, port == 0);
        end
        check_packet($sformatf("output port %0d", port + 1), exp_q[port][0], pkt);
        void'(exp_q[port].pop_front());
        out_count++;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (resend) begin
                check_packet("output during resend", '0, dout_leaf_interface2bft);
            end
            if (!started) begin
                check_level("output valid before ap_start", 1'b0, dout_leaf_interface2bft.valid);
            end
            if (dout_leaf_interface2bft.valid) begin
                match_output(dout_leaf_interface2bft);
            end
        end
    end

    initial begin
        int phase_sent;
        clk                    = 1'b0;
        rst_n                  = 1'b0;
        resend                 = 1'b0;
        ap_start               = 1'b0;
        din_leaf_bft2interface = '0;
        rng_state              = 32'h77c6_2c35;
        out_count              = 0;
        resend_left            = 0;
        started                = 1'b0;
        model_target           = 0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            tbl_leaf[i]  = '0;
            tbl_port[i]  = '0;
            model_seq[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;

        // words sent while the kernel is still held in reset.
        reconfigure(1'b1);
        repeat (8) send_data();
        repeat (30) next_cycle('0);
        ap_start = 1'b1;
        started  = 1'b1;
        next_cycle('0);
        ap_start = 1'b0;
        wait_drained("words sent before ap_start");

        for (int phase = 0; phase < 4; phase++) begin
            if (phase > 0) begin
                reconfigure(1'b0);
            end
            phase_sent = 0;
            while (phase_sent < PHASE_WORDS) begin
                if (rand_below(6) == 0) begin
                    send_junk();
                end else begin
                    send_data();
                    phase_sent++;
                end
            end
            wait_drained($sformatf("traffic phase %0d", phase));
        end

        // any extra output in these idle cycles has no pending word to match.
        repeat (20) next_cycle('0);
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hdl/leaf_pkg.sv
hdl/leaf_rx_depacketizer.sv
hdl/leaf_tx_packetizer.sv
hdl/leaf_interface.sv
hdl/user_kernel.sv
hdl/leaf_top.sv
testbench/tb_leaf_top.sv
